// File: include/aud_defines.svh
`ifndef AUD_DEFINES_SVH
`define AUD_DEFINES_SVH

// Bits per audio sample, MSB first on the wire
`define AUD_SAMPLE_W 16

// Word address into the sample memory
`define AUD_ADDR_W 20

`define AUD_DEFAULT_LIMIT 20'd1024000 // Limit register value out of reset

`endif

// File: design/aud_pkg.sv
`include "aud_defines.svh"

package aud_pkg;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        WAIT   = 3'd1,
        REC    = 3'd2,
        PAUSE  = 3'd3,
        FINISH = 3'd4
    } aud_state_e;

    // Command register layout
    typedef struct packed {
        logic [`AUD_ADDR_W-4:0] rsvd;
        logic                   stop;
        logic                   pause;  // Level, held until rewritten
        logic                   start;
    } host_cmd_t;

    // Host write word, view picked by the register select
    typedef union packed {
        host_cmd_t              cmd;
        logic [`AUD_ADDR_W-1:0] limit;
    } host_wdata_u;

    typedef struct packed {
        aud_state_e             state;
        logic                   done;
        logic                   overrun;
        logic [`AUD_ADDR_W-1:0] words;
    } rec_status_t;

    typedef struct packed {
        logic [`AUD_ADDR_W-1:0]   addr;
        logic [`AUD_SAMPLE_W-1:0] data;
    } rec_sample_t;

endpackage

// File: design/aud_ctrl_regs.sv
`include "aud_defines.svh"

module aud_ctrl_regs (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_host_req,
    input  logic                    i_host_we,
    input  logic                    i_host_sel,
    input  aud_pkg::host_wdata_u    i_host_wdata,
    input  aud_pkg::aud_state_e     i_state,
    input  logic                    i_done,
    input  logic                    i_overrun,
    input  logic [`AUD_ADDR_W-1:0]  i_words,
    output logic                    o_host_ack,
    output logic [31:0]             o_host_rdata,
    output logic                    o_start,
    output logic                    o_pause,
    output logic                    o_stop,
    output logic [`AUD_ADDR_W-1:0]  o_limit
);
    import aud_pkg::*;

    localparam logic [1:0] H_IDLE = 2'd0;
    localparam logic [1:0] H_EXEC = 2'd1;
    localparam logic [1:0] H_ACK  = 2'd2;

    logic [1:0]              hstate_r;
    logic                    req_q;
    logic                    ack_r;
    logic [31:0]             rdata_r;
    logic                    start_r;
    logic                    stop_r;
    logic                    pause_r;
    logic [`AUD_ADDR_W-1:0]  limit_r;
    logic                    wr_cmd;
    logic                    wr_lim;
    rec_status_t             status;

    assign wr_cmd = (hstate_r == H_EXEC) && i_host_we && !i_host_sel;
    assign wr_lim = (hstate_r == H_EXEC) && i_host_we && i_host_sel;

    always_comb begin
        status.state   = i_state;
        status.done    = i_done;
        status.overrun = i_overrun;
        status.words   = i_words;
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            hstate_r <= H_IDLE;
            req_q    <= 1'b0;
            ack_r    <= 1'b0;
            start_r  <= 1'b0;
            stop_r   <= 1'b0;
            pause_r  <= 1'b0;
            limit_r  <= `AUD_DEFAULT_LIMIT;
        end else begin
            req_q   <= i_host_req;
            start_r <= wr_cmd && i_host_wdata.cmd.start; // One cycle pulses
            stop_r  <= wr_cmd && i_host_wdata.cmd.stop;
            if (wr_cmd) begin
                pause_r <= i_host_wdata.cmd.pause;
            end
            if (wr_lim) begin
                limit_r <= i_host_wdata.limit;
            end
            case (hstate_r)
                H_IDLE: begin
                    if (req_q) begin
                        hstate_r <= H_EXEC;
                    end
                end
                H_EXEC: begin
                    hstate_r <= H_ACK;
                    ack_r    <= 1'b1;
                end
                H_ACK: begin
                    if (!req_q) begin  // Host has let go
                        hstate_r <= H_IDLE;
                        ack_r    <= 1'b0;
                    end
                end
                default: hstate_r <= H_IDLE;
            endcase
        end
    end

    // Read snapshot, held for the whole ack phase
    always_ff @(posedge i_clk) begin
        if (hstate_r == H_EXEC) begin
            rdata_r <= i_host_sel ? 32'(limit_r) : 32'(status);
        end
    end

    assign o_host_ack   = ack_r;
    assign o_host_rdata = rdata_r;
    assign o_start      = start_r;
    assign o_pause      = pause_r;
    assign o_stop       = stop_r;
    assign o_limit      = limit_r;

    a_ack_needs_req: assert property (@(posedge i_clk) disable iff (i_rst_n)
        $rose(o_host_ack) |-> $past(i_host_req));

endmodule

// File: design/aud_recorder.sv
`include "aud_defines.svh"

module aud_recorder (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_lrc,
    input  logic                    i_data,
    input  logic                    i_start,
    input  logic                    i_pause,
    input  logic                    i_stop,
    input  logic [`AUD_ADDR_W-1:0]  i_limit,
    output aud_pkg::aud_state_e     o_state,
    output logic                    o_done,
    output logic [`AUD_ADDR_W-1:0]  o_words,
    output logic                    o_smp_valid,
    output aud_pkg::rec_sample_t    o_smp
);
    import aud_pkg::*;

    localparam int CNT_W = $clog2(`AUD_SAMPLE_W);

    aud_state_e                state_r;
    aud_state_e                state_w;
    logic [CNT_W-1:0]          bit_cnt_r;
    logic [`AUD_SAMPLE_W-1:0]  shift_r;
    logic [`AUD_ADDR_W-1:0]    addr_r;
    logic                      done_r;
    logic                      smp_valid_r;
    rec_sample_t               smp_r;
    logic                      shift_en;
    logic                      word_end;
    logic [`AUD_ADDR_W-1:0]    addr_inc;

    // Left channel only, and nothing once pause or stop shows up
    assign shift_en = (state_r == REC) && !i_lrc && !i_pause && !i_stop;
    assign word_end = shift_en && (bit_cnt_r == CNT_W'(`AUD_SAMPLE_W - 1));
    assign addr_inc = addr_r + 1'b1;

    always_comb begin
        state_w = state_r;
        case (state_r)
            IDLE: begin
                if (i_start) begin
                    state_w = WAIT;
                end
            end
            WAIT: state_w = i_stop ? FINISH : REC;
            REC: begin
                if (i_stop || (word_end && addr_inc == i_limit)) begin
                    state_w = FINISH;
                end else if (i_pause) begin
                    state_w = PAUSE;
                end
            end
            PAUSE: begin
                if (i_stop) begin
                    state_w = FINISH;
                end else if (!i_pause) begin
                    state_w = REC;
                end
            end
            FINISH:  state_w = IDLE;
            default: state_w = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r     <= IDLE;
            bit_cnt_r   <= '0;
            addr_r      <= '0;
            done_r      <= 1'b0;
            smp_valid_r <= 1'b0;
        end else begin
            state_r     <= state_w;
            smp_valid_r <= word_end;
            if (state_r == IDLE && i_start) begin
                addr_r    <= '0;
                done_r    <= 1'b0;
                bit_cnt_r <= '0;
            end else if (state_w == FINISH) begin
                bit_cnt_r <= '0; // Partial word dropped
            end else if (word_end) begin
                bit_cnt_r <= '0;
            end else if (shift_en) begin
                bit_cnt_r <= bit_cnt_r + 1'b1;
            end
            if (word_end) begin
                addr_r <= addr_inc;
            end
            if (state_r == FINISH) begin
                done_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (shift_en) begin
            shift_r <= {shift_r[`AUD_SAMPLE_W-2:0], i_data};
        end
        if (word_end) begin
            smp_r.addr <= addr_r;  // Address before the increment
            smp_r.data <= {shift_r[`AUD_SAMPLE_W-2:0], i_data};
        end
    end

    assign o_state     = state_r;
    assign o_done      = done_r;
    assign o_words     = addr_r;
    assign o_smp_valid = smp_valid_r;
    assign o_smp       = smp_r;

    // Sample leaves right after the count wraps, address already moved on
    a_smp_after_wrap: assert property (@(posedge i_clk) disable iff (i_rst_n)
        o_smp_valid |-> ($past(bit_cnt_r) == CNT_W'(`AUD_SAMPLE_W - 1))
                        && (bit_cnt_r == '0) && (o_words == o_smp.addr + 1'b1));

endmodule

// File: design/aud_sram_writer.sv
module aud_sram_writer (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_smp_valid,
    input  aud_pkg::rec_sample_t  i_smp,
    input  logic                  i_start,
    input  logic                  i_mem_ack,
    output logic                  o_mem_req,
    output aud_pkg::rec_sample_t  o_mem_wr,
    output logic                  o_overrun
);
    import aud_pkg::*;

    rec_sample_t  buf_r;
    logic         full_r;
    logic         req_r;
    logic         overrun_r;
    logic         freeing;
    logic         accept;

    // Ack low again after req dropped ends the transfer
    assign freeing = full_r && !req_r && !i_mem_ack;
    assign accept  = i_smp_valid && (!full_r || freeing);

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            full_r    <= 1'b0;
            req_r     <= 1'b0;
            overrun_r <= 1'b0;
        end else begin
            if (accept) begin
                full_r <= 1'b1;
                req_r  <= 1'b1;
            end else if (freeing) begin
                full_r <= 1'b0;
            end else if (req_r && i_mem_ack) begin
                req_r <= 1'b0;
            end
            if (i_start) begin
                overrun_r <= 1'b0;
            end else if (i_smp_valid && !accept) begin
                overrun_r <= 1'b1; // Sticky, sample lost
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            buf_r <= i_smp;
        end
    end

    assign o_mem_req = req_r;
    assign o_mem_wr  = buf_r;
    assign o_overrun = overrun_r;

    a_wr_stable: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (o_mem_req && !i_mem_ack) |=> $stable(o_mem_wr));

endmodule

// File: design/aud_record_top.sv
`include "aud_defines.svh"

module aud_record_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_host_req,
    input  logic                  i_host_we,
    input  logic                  i_host_sel,
    input  aud_pkg::host_wdata_u  i_host_wdata,
    output logic                  o_host_ack,
    output logic [31:0]           o_host_rdata,
    input  logic                  i_lrc,
    input  logic                  i_data,
    output logic                  o_mem_req,
    output aud_pkg::rec_sample_t  o_mem_wr,
    input  logic                  i_mem_ack
);
    import aud_pkg::*;

    aud_state_e              state;
    logic                    done;
    logic                    overrun;
    logic                    start;
    logic                    pause;
    logic                    stop;
    logic [`AUD_ADDR_W-1:0]  limit;
    logic [`AUD_ADDR_W-1:0]  words;
    logic                    smp_valid;
    rec_sample_t             smp;

    aud_ctrl_regs u_regs (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_host_req   (i_host_req),
        .i_host_we    (i_host_we),
        .i_host_sel   (i_host_sel),
        .i_host_wdata (i_host_wdata),
        .i_state      (state),
        .i_done       (done),
        .i_overrun    (overrun),
        .i_words      (words),
        .o_host_ack   (o_host_ack),
        .o_host_rdata (o_host_rdata),
        .o_start      (start),
        .o_pause      (pause),
        .o_stop       (stop),
        .o_limit      (limit)
    );

    aud_recorder u_rec (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_lrc       (i_lrc),
        .i_data      (i_data),
        .i_start     (start),
        .i_pause     (pause),
        .i_stop      (stop),
        .i_limit     (limit),
        .o_state     (state),
        .o_done      (done),
        .o_words     (words),
        .o_smp_valid (smp_valid),
        .o_smp       (smp)
    );

    aud_sram_writer u_wr (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_smp_valid (smp_valid),
        .i_smp       (smp),
        .i_start     (start),
        .i_mem_ack   (i_mem_ack),
        .o_mem_req   (o_mem_req),
        .o_mem_wr    (o_mem_wr),
        .o_overrun   (overrun)
    );

endmodule

// File: testbench/tb_aud_record.sv
`include "aud_defines.svh"

module tb_aud_record;
    import aud_pkg::*;

    localparam int HOST_TIMEOUT  = 50;
    localparam int MEM_TIMEOUT   = 200;
    localparam int DRAIN_TIMEOUT = 400;

    logic                      i_clk;
    logic                      i_rst_n;
    logic                      i_host_req;
    logic                      i_host_we;
    logic                      i_host_sel;
    host_wdata_u               i_host_wdata;
    logic                      o_host_ack;
    logic [31:0]               o_host_rdata;
    logic                      i_lrc;
    logic                      i_data;
    logic                      o_mem_req;
    rec_sample_t               o_mem_wr;
    logic                      i_mem_ack;

    integer                    seed;
    int                        ack_delay;  // Negedges from req to ack
    int                        err_count;
    int                        errs_at_open;
    int                        test_count;
    int                        test_fail;
    bit                        hung;
    event                      hang_ev;
    rec_sample_t               mem_log[$];
    logic [`AUD_SAMPLE_W-1:0]  sent[$];  // Words expected in memory in order

    aud_record_top uut (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_host_req   (i_host_req),
        .i_host_we    (i_host_we),
        .i_host_sel   (i_host_sel),
        .i_host_wdata (i_host_wdata),
        .o_host_ack   (o_host_ack),
        .o_host_rdata (o_host_rdata),
        .i_lrc        (i_lrc),
        .i_data       (i_data),
        .o_mem_req    (o_mem_req),
        .o_mem_wr     (o_mem_wr),
        .i_mem_ack    (i_mem_ack)
    );

    always #4 i_clk = ~i_clk;

    task automatic log_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        err_count++;
    endtask

    task abort_on_timeout(input string msg);
        $display("Timeout at %0t: %s", $time, msg);
        hung = 1'b1;
        -> hang_ev;
        forever @(negedge i_clk);
    endtask

    // Memory side of the four-phase write handshake
    always begin : mem_model
        int n;
        @(negedge i_clk);
        if (o_mem_req === 1'b1 && !i_mem_ack) begin
            repeat (ack_delay) @(negedge i_clk);
            mem_log.push_back(o_mem_wr);
            i_mem_ack = 1'b1;
            n = 0;
            while (o_mem_req && n < MEM_TIMEOUT) begin
                @(negedge i_clk);
                n++;
            end
            if (o_mem_req) begin
                abort_on_timeout("memory request stayed high after ack");
            end
            i_mem_ack = 1'b0;
        end
    end

    task automatic wait_host_ack(input logic level);
        int n;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
        end while (o_host_ack !== level && n < HOST_TIMEOUT);
        if (o_host_ack !== level) begin
            abort_on_timeout(level ? "host ack never rose" : "host ack never fell");
        end
    endtask

    task automatic host_write(input logic sel, input host_wdata_u wdata);
        @(negedge i_clk);
        i_host_sel   = sel;
        i_host_we    = 1'b1;
        i_host_wdata = wdata;
        i_host_req   = 1'b1;
        wait_host_ack(1'b1);
        i_host_req = 1'b0;
        i_host_we  = 1'b0;
        wait_host_ack(1'b0);
    endtask

    task automatic host_read(input logic sel, output logic [31:0] rdata);
        @(negedge i_clk);
        i_host_sel = sel;
        i_host_we  = 1'b0;
        i_host_req = 1'b1;
        wait_host_ack(1'b1);
        rdata      = o_host_rdata;
        i_host_req = 1'b0;
        wait_host_ack(1'b0);
    endtask

    task automatic send_command(input logic start, input logic pause, input logic stop);
        host_wdata_u w;
        w.cmd.rsvd  = '0;
        w.cmd.start = start;
        w.cmd.pause = pause;
        w.cmd.stop  = stop;
        host_write(1'b0, w);
    endtask

    task automatic set_limit(input logic [`AUD_ADDR_W-1:0] limit);
        host_wdata_u w;
        w.limit = limit;
        host_write(1'b1, w);
    endtask

    task automatic fetch_status(output rec_status_t st);
        logic [31:0] d;
        host_read(1'b0, d);
        if (d[31:$bits(rec_status_t)] != '0) begin
            log_error($sformatf("status upper bits %h, expected zero",
                                d[31:$bits(rec_status_t)]));
        end
        st = d[$bits(rec_status_t)-1:0];
    endtask

    task automatic expect_status(input aud_state_e st_exp, input logic done_exp,
                                 input logic ovr_exp, input int words_exp);
        rec_status_t st;
        fetch_status(st);
        if (st.state != st_exp) begin
            log_error($sformatf("status state %0d, expected %0d", st.state, st_exp));
        end
        if (st.done != done_exp) begin
            log_error($sformatf("status done %0b, expected %0b", st.done, done_exp));
        end
        if (st.overrun != ovr_exp) begin
            log_error($sformatf("status overrun %0b, expected %0b", st.overrun, ovr_exp));
        end
        if (st.words != `AUD_ADDR_W'(words_exp)) begin
            log_error($sformatf("status words %0d, expected %0d", st.words, words_exp));
        end
    endtask

    // Left channel slot sent MSB first
    task automatic shift_left_bits(input logic [`AUD_SAMPLE_W-1:0] word, input int nbits);
        for (int i = 0; i < nbits; i++) begin
            @(negedge i_clk);
            i_lrc  = 1'b0;
            i_data = word[`AUD_SAMPLE_W-1-i];
        end
    endtask

    task automatic idle_right_channel(input int ncycles);
        for (int i = 0; i < ncycles; i++) begin
            @(negedge i_clk);
            i_lrc  = 1'b1;
            i_data = $random(seed); // Must not reach memory
        end
    endtask

    task automatic stream_words(input int n, input bit keep);
        logic [`AUD_SAMPLE_W-1:0] w;
        for (int k = 0; k < n; k++) begin
            w = $random(seed);
            shift_left_bits(w, `AUD_SAMPLE_W);
            idle_right_channel(`AUD_SAMPLE_W);
            if (keep) begin
                sent.push_back(w);
            end
        end
    endtask

    task automatic wait_mem_idle();
        int idle;
        int n;
        idle = 0;
        n    = 0;
        while (idle < 4 && n < DRAIN_TIMEOUT) begin
            @(negedge i_clk);
            n++;
            if (!o_mem_req && !i_mem_ack) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
        if (idle < 4) begin
            abort_on_timeout("memory writes never settled");
        end
    endtask

    // Entry i holds address i*step and the word sent at that address
    task automatic compare_log(input int n_exp, input int step);
        if (mem_log.size() != n_exp) begin
            log_error($sformatf("%0d memory writes, expected %0d", mem_log.size(), n_exp));
        end
        for (int i = 0; i < n_exp && i < mem_log.size() && i * step < sent.size(); i++) begin
            if (mem_log[i].addr != `AUD_ADDR_W'(i * step)) begin
                log_error($sformatf("write %0d at address %0d, expected %0d",
                                    i, mem_log[i].addr, i * step));
            end
            if (mem_log[i].data != sent[i * step]) begin
                log_error($sformatf("write %0d data %h, expected %h",
                                    i, mem_log[i].data, sent[i * step]));
            end
        end
    endtask

    task automatic open_test();
        errs_at_open = err_count;
        mem_log.delete();
        sent.delete();
    endtask

    task automatic close_test(input string name);
        test_count++;
        if (err_count != errs_at_open) begin
            test_fail++;
            $display("Test %s: failed with %0d errors", name, err_count - errs_at_open);
        end else begin
            $display("Test %s: ok", name);
        end
    endtask

    task automatic readback_after_reset();
        rec_status_t st;
        logic [31:0] d;
        open_test();
        expect_status(IDLE, 1'b0, 1'b0, 0);
        host_read(1'b1, d);
        if (d != {12'd0, `AUD_DEFAULT_LIMIT}) begin
            log_error($sformatf("limit reads %0d after reset", d));
        end
        send_command(1'b1, 1'b0, 1'b0);
        fetch_status(st);
        if (st.state != REC && st.state != WAIT) begin
            log_error($sformatf("state %0d after start, expected REC or WAIT", st.state));
        end
        send_command(1'b0, 1'b0, 1'b1);
        close_test("register readback");
    endtask

    task automatic basic_capture();
        open_test();
        send_command(1'b1, 1'b0, 1'b0);
        stream_words(8, 1'b1);
        send_command(1'b0, 1'b0, 1'b1);
        wait_mem_idle();
        compare_log(8, 1);
        expect_status(IDLE, 1'b1, 1'b0, 8);
        close_test("basic capture");
    endtask

    task automatic pause_resume();
        open_test();
        send_command(1'b1, 1'b0, 1'b0);
        stream_words(2, 1'b1);
        send_command(1'b0, 1'b1, 1'b0);
        stream_words(1, 1'b0);  // Dropped while paused
        send_command(1'b0, 1'b0, 1'b0);
        stream_words(2, 1'b1);
        send_command(1'b0, 1'b0, 1'b1);
        wait_mem_idle();
        compare_log(4, 1);
        expect_status(IDLE, 1'b1, 1'b0, 4);
        close_test("pause");
    endtask

    task automatic stop_mid_word();
        open_test();
        send_command(1'b1, 1'b0, 1'b0);
        stream_words(3, 1'b1);
        shift_left_bits(16'ha5c3, 7);
        idle_right_channel(2);
        send_command(1'b0, 1'b0, 1'b1);
        expect_status(IDLE, 1'b1, 1'b0, 3);
        wait_mem_idle();
        compare_log(3, 1);
        close_test("stop mid-word");
    endtask

    task automatic length_limit();
        open_test();
        set_limit(`AUD_ADDR_W'(5));
        send_command(1'b1, 1'b0, 1'b0);
        stream_words(8, 1'b1);
        wait_mem_idle();
        compare_log(5, 1);
        expect_status(IDLE, 1'b1, 1'b0, 5);
        set_limit(`AUD_DEFAULT_LIMIT);
        close_test("length limit");
    endtask

    // Ack slower than one word period drops every second sample
    task automatic overrun_recovery();
        open_test();
        ack_delay = 40;
        send_command(1'b1, 1'b0, 1'b0);
        stream_words(6, 1'b1);
        wait_mem_idle();
        compare_log(3, 2);
        expect_status(REC, 1'b0, 1'b1, 6);
        send_command(1'b0, 1'b0, 1'b1);
        ack_delay = 1;
        send_command(1'b1, 1'b0, 1'b0);
        expect_status(REC, 1'b0, 1'b0, 0);
        send_command(1'b0, 1'b0, 1'b1);
        close_test("overrun");
    endtask

    task automatic run_tests();
        readback_after_reset();
        basic_capture();
        pause_resume();
        stop_mid_word();
        length_limit();
        overrun_recovery();
    endtask

    initial begin
        i_clk        = 1'b0;
        i_rst_n      = 1'b1;  // Reset is active high
        i_host_req   = 1'b0;
        i_host_we    = 1'b0;
        i_host_sel   = 1'b0;
        i_host_wdata = '0;
        i_lrc        = 1'b1;
        i_data       = 1'b0;
        i_mem_ack    = 1'b0;
        seed         = 32'hb809_caa5;
        ack_delay    = 1;
        err_count    = 0;
        errs_at_open = 0;
        test_count   = 0;
        test_fail    = 0;
        hung         = 1'b0;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b0;
        fork
            run_tests();
            @(hang_ev);
        join_any
        disable fork;
        $display("Tests run %0d, failed %0d, errors %0d", test_count, test_fail, err_count);
        if (!hung && err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
design/aud_pkg.sv
design/aud_ctrl_regs.sv
design/aud_recorder.sv
design/aud_sram_writer.sv
design/aud_record_top.sv
testbench/tb_aud_record.sv

// File: Bender.yml
package:
  name: aud_record

sources:
  - include_dirs:
      - include
    files:
      - design/aud_pkg.sv
      - design/aud_ctrl_regs.sv
      - design/aud_recorder.sv
      - design/aud_sram_writer.sv
      - design/aud_record_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_aud_record.sv
